// File: build.f
common/ooo_pkg.sv
verilog/exec_lane.sv
verilog/data_mem.sv
issue/issue_select.sv
issue/res_station_file.sv
rob/reorder_buffer.sv
rob/load_store_queue.sv
verilog/ooo_core.sv
testbench/tb_clock.sv
testbench/ooo_core_props.sv
testbench/ooo_core_tb.sv

// File: Makefile
TOP = ooo_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "SIMULATION FAILED" >> sim.log
	cat sim.log
	! grep -q "SIMULATION FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/ooo_core_tb.sv
`timescale 1ns/100ps

module ooo_core_tb;
  localparam int n_inst = 60;
  localparam int limit  = 400;

  logic                 clk, rst_n;
  logic                 disp_req, disp_ack, commit_req, commit_ack, commit_is_store;
  ooo_pkg::control_bits ctrl;
  ooo_pkg::tag_t        src1_tag, src2_tag, disp_tag, commit_tag;
  ooo_pkg::word_t       src1_value, src2_value, imm, commit_result, commit_store_data;

  // Program and in-order model results
  ooo_pkg::control_bits p_ctrl [n_inst];
  int                   p_ref1 [n_inst];
  int                   p_ref2 [n_inst];
  ooo_pkg::word_t       p_val1 [n_inst];
  ooo_pkg::word_t       p_val2 [n_inst];
  ooo_pkg::word_t       p_imm [n_inst];
  ooo_pkg::word_t       exp_result [n_inst];
  ooo_pkg::word_t       exp_sdata [n_inst];
  logic                 exp_store [n_inst];
  ooo_pkg::word_t       model_mem [16];

  // Rename state kept by the front end
  ooo_pkg::tag_t        tag_of [n_inst];
  logic                 inst_done [n_inst];
  int                   tag_owner [256];

  logic [31:0]          rng_state;
  int                   value_errs, proto_errs;

  tb_clock clk0 (.clk(clk), .rst_n(rst_n));

  ooo_core #(.rob_size(8), .rs_size(4), .lsq_size(4)) dut0 (
    .clk, .rst_n, .disp_req, .ctrl, .src1_tag, .src1_value, .src2_tag, .src2_value,
    .imm, .disp_ack, .disp_tag, .commit_req, .commit_tag, .commit_result,
    .commit_is_store, .commit_store_data, .commit_ack
  );

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Earlier producer among the last three, or none
  function int pick_ref(int i);
    logic [31:0] r;
    int          d;
    r = next_rand();
    d = 1 + int'(r[7:1] % 3);
    if (r[0] && i - d >= 0)
      return i - d;
    return -1;
  endfunction

  function ooo_pkg::word_t operand(int src, ooo_pkg::word_t v);
    return (src >= 0) ? exp_result[src] : v;
  endfunction

  function ooo_pkg::word_t alu(logic [1:0] op, ooo_pkg::word_t a, ooo_pkg::word_t b);
    case (op)
      2'd1:    return a - b;
      2'd2:    return a & b;
      2'd3:    return a ^ b;
      default: return a + b;
    endcase
  endfunction

  task automatic build_program();
    logic [31:0]          r;
    int                   k;
    ooo_pkg::control_bits c;
    ooo_pkg::word_t       a, b, addr;
    for (int i = 0; i < n_inst; i++) begin
      r = next_rand();
      k = int'(r % 10);
      c = '0;
      p_imm[i] = next_rand() & 32'hff;
      p_val1[i] = next_rand();
      p_val2[i] = next_rand();
      p_ref1[i] = pick_ref(i);
      p_ref2[i] = pick_ref(i);
      a = operand(p_ref1[i], p_val1[i]);
      b = operand(p_ref2[i], p_val2[i]);
      exp_store[i] = 1'b0;
      exp_sdata[i] = '0;
      addr = a + p_imm[i];
      if (k < 6) begin
        c.alu_op = ooo_pkg::alu_op_t'(r[9:8]);
        c.alusrc = (k >= 3);
        exp_result[i] = alu(r[9:8], a, c.alusrc ? p_imm[i] : b);
      end else if (k < 8) begin
        c.memtoreg = 1'b1;
        c.alusrc = 1'b1;
        exp_result[i] = model_mem[addr[3:0]];
      end else if (k == 8) begin
        c.memtoreg = 1'b1;
        c.memwr = 1'b1;
        c.alusrc = 1'b1;
        model_mem[addr[3:0]] = b;
        exp_result[i] = addr;
        exp_sdata[i] = b;
        exp_store[i] = 1'b1;
      end else begin
        // Jump writes back its sum
        c.alusrc = r[12];
        c.cjump = r[13];
        c.ucjump = !r[13];
        exp_result[i] = a + (c.alusrc ? p_imm[i] : b);
      end
      p_ctrl[i] = c;
    end
  endtask

  // Producer result already broadcast, or on the bus right now
  function automatic logic result_known(int p);
    return inst_done[p] ||
           (dut0.cdb_valid1 && dut0.cdb_tag1 == tag_of[p]) ||
           (dut0.cdb_valid2 && dut0.cdb_tag2 == tag_of[p]);
  endfunction

  // Tag while the producer has not broadcast, otherwise its value
  task automatic set_sources(int i);
    if (p_ref1[i] >= 0 && !result_known(p_ref1[i])) begin
      src1_tag = tag_of[p_ref1[i]];
      src1_value = '0;
    end else begin
      src1_tag = '0;
      src1_value = operand(p_ref1[i], p_val1[i]);
    end
    if (p_ref2[i] >= 0 && !result_known(p_ref2[i])) begin
      src2_tag = tag_of[p_ref2[i]];
      src2_value = '0;
    end else begin
      src2_tag = '0;
      src2_value = operand(p_ref2[i], p_val2[i]);
    end
  endtask

  task automatic timeout_fail(string what);
    $display("Timeout while waiting for %s at %0t", what, $time);
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs + 1);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic report_mismatch(string what, int n, ooo_pkg::word_t got,
                                 ooo_pkg::word_t exp);
    value_errs++;
    $display("[FAIL] %0t: instruction %0d %s got %h expected %h", $time, n, what, got, exp);
  endtask

  // Broadcasts seen by the front end
  always @(negedge clk) begin
    if (rst_n) begin
      if (dut0.cdb_valid1 && tag_owner[dut0.cdb_tag1] >= 0)
        inst_done[tag_owner[dut0.cdb_tag1]] = 1'b1;
      if (dut0.cdb_valid2 && tag_owner[dut0.cdb_tag2] >= 0)
        inst_done[tag_owner[dut0.cdb_tag2]] = 1'b1;
    end
  end

  task automatic dispatch_one(int i);
    int cnt;
    @(negedge clk);
    ctrl = p_ctrl[i];
    imm = p_imm[i];
    set_sources(i);
    disp_req = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!disp_ack) begin
      if (cnt == limit)
        timeout_fail("disp_ack to rise");
      set_sources(i);
      cnt++;
      @(negedge clk);
    end
    tag_of[i] = disp_tag;
    tag_owner[disp_tag] = i;
    disp_req = 1'b0;
    cnt = 0;
    @(negedge clk);
    while (disp_ack) begin
      if (cnt == limit)
        timeout_fail("disp_ack to fall");
      cnt++;
      @(negedge clk);
    end
  endtask

  task automatic commit_all();
    int cnt;
    int delay;
    for (int n = 0; n < n_inst; n++) begin
      cnt = 0;
      @(negedge clk);
      while (!commit_req) begin
        if (cnt == limit)
          timeout_fail("commit_req to rise");
        cnt++;
        @(negedge clk);
      end
      assert (commit_tag == tag_of[n])
        else report_mismatch("commit tag", n, commit_tag, tag_of[n]);
      assert (commit_result == exp_result[n])
        else report_mismatch("result", n, commit_result, exp_result[n]);
      assert (commit_is_store == exp_store[n])
        else report_mismatch("store flag", n, commit_is_store, exp_store[n]);
      if (exp_store[n]) begin
        assert (commit_store_data == exp_sdata[n])
          else report_mismatch("store data", n, commit_store_data, exp_sdata[n]);
      end
      delay = int'(next_rand() % 4);
      repeat (delay) @(negedge clk);
      commit_ack = 1'b1;
      cnt = 0;
      @(negedge clk);
      while (commit_req) begin
        if (cnt == limit)
          timeout_fail("commit_req to fall");
        cnt++;
        @(negedge clk);
      end
      commit_ack = 1'b0;
    end
  endtask

  initial begin
    int cnt;
    disp_req = 1'b0;
    ctrl = '0;
    src1_tag = '0;
    src1_value = '0;
    src2_tag = '0;
    src2_value = '0;
    imm = '0;
    commit_ack = 1'b0;
    rng_state = 32'd62;
    value_errs = 0;
    proto_errs = 0;
    for (int i = 0; i < 16; i++)
      model_mem[i] = '0;
    for (int i = 0; i < 256; i++)
      tag_owner[i] = -1;
    for (int i = 0; i < n_inst; i++) begin
      inst_done[i] = 1'b0;
      tag_of[i] = '0;
    end
    build_program();

    cnt = 0;
    while (!rst_n) begin
      if (cnt == 20)
        timeout_fail("reset release");
      cnt++;
      @(negedge clk);
    end

    fork
      begin
        for (int i = 0; i < n_inst; i++)
          dispatch_one(i);
      end
      commit_all();
    join

    // Nothing may remain to commit
    repeat (10) @(negedge clk);
    assert (!commit_req) else begin
      proto_errs++;
      $display("Extra commit request after the last instruction at %0t", $time);
    end

    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: testbench/ooo_core_props.sv
`timescale 1ns/100ps

module ooo_core_props #(
  parameter int rob_size = 8,
  parameter int lsq_size = 4
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 disp_req,
  input logic                 disp_ack,
  input logic                 commit_req,
  input logic                 commit_ack,
  input logic                 grant_valid1,
  input logic                 grant_valid2,
  input ooo_pkg::control_bits ctrl_bits1,
  input ooo_pkg::control_bits ctrl_bits2,
  input ooo_pkg::tag_t        tag1,
  input ooo_pkg::tag_t        tag2,
  input ooo_pkg::tag_t        lsq_id_1,
  input ooo_pkg::tag_t        lsq_id_2,
  input ooo_pkg::rob_entry    rob [rob_size-1:0],
  input ooo_pkg::lsq_entry    lsq [lsq_size-1:0],
  input ooo_pkg::tag_t        rob_head,
  input ooo_pkg::tag_t        lsq_head
);
  // Walk from the queue head up to the given entry
  function automatic logic store_before(ooo_pkg::tag_t id);
    ooo_pkg::tag_t j;
    logic          found;
    j = lsq_head;
    found = 1'b0;
    for (int k = 0; k < lsq_size; k++) begin
      if (j == id)
        break;
      if (lsq[j-1].busy && lsq[j-1].is_store)
        found = 1'b1;
      j = ooo_pkg::wrap_inc(j, lsq_size);
    end
    return found;
  endfunction

  function automatic logic jump_before(ooo_pkg::tag_t t);
    ooo_pkg::tag_t j;
    logic          found;
    j = rob_head;
    found = 1'b0;
    for (int k = 0; k < rob_size; k++) begin
      if (j == t)
        break;
      if (rob[j-1].busy && (rob[j-1].ctrl_bits.cjump || rob[j-1].ctrl_bits.ucjump))
        found = 1'b1;
      j = ooo_pkg::wrap_inc(j, rob_size);
    end
    return found;
  endfunction

  a_load_slot1: assert property (@(posedge clk) disable iff (!rst_n)
    grant_valid1 && ctrl_bits1.memtoreg && !ctrl_bits1.memwr |->
      !store_before(lsq_id_1) && !jump_before(tag1))
    else $error("load in slot 1 issued past an older store or jump");

  a_load_slot2: assert property (@(posedge clk) disable iff (!rst_n)
    grant_valid2 && ctrl_bits2.memtoreg && !ctrl_bits2.memwr |->
      !store_before(lsq_id_2) && !jump_before(tag2))
    else $error("load in slot 2 issued past an older store or jump");

  // The ack registers on the edge that sees req, so req may fall as ack shows
  a_disp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    disp_req && !disp_ack |=> disp_req || disp_ack)
    else $error("disp_req dropped before disp_ack");

  a_commit_hold: assert property (@(posedge clk) disable iff (!rst_n)
    commit_req && !commit_ack |=> commit_req)
    else $error("commit_req dropped before commit_ack");

endmodule

bind ooo_core ooo_core_props #(.rob_size(rob_size), .lsq_size(lsq_size)) props0 (
  .clk(clk), .rst_n(rst_n), .disp_req(disp_req), .disp_ack(disp_ack),
  .commit_req(commit_req), .commit_ack(commit_ack),
  .grant_valid1(grant_valid1), .grant_valid2(grant_valid2),
  .ctrl_bits1(ctrl_bits1), .ctrl_bits2(ctrl_bits2), .tag1(tag1), .tag2(tag2),
  .lsq_id_1(lsq_id1), .lsq_id_2(lsq_id2),
  .rob(rob), .lsq(lsq), .rob_head(rob_head), .lsq_head(lsq_head)
);

// File: testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic rst_n
);
  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Reset held for four cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: verilog/ooo_core.sv
`timescale 1ns/100ps

module ooo_core #(
  parameter int rob_size = 8,
  parameter int rs_size  = 4,
  parameter int lsq_size = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 disp_req,
  input  ooo_pkg::control_bits ctrl,
  input  ooo_pkg::tag_t        src1_tag,
  input  ooo_pkg::word_t       src1_value,
  input  ooo_pkg::tag_t        src2_tag,
  input  ooo_pkg::word_t       src2_value,
  input  ooo_pkg::word_t       imm,
  output logic                 disp_ack,
  output ooo_pkg::tag_t        disp_tag,
  output logic                 commit_req,
  output ooo_pkg::tag_t        commit_tag,
  output ooo_pkg::word_t       commit_result,
  output logic                 commit_is_store,
  output ooo_pkg::word_t       commit_store_data,
  input  logic                 commit_ack
);
  localparam int rs_w = $clog2(rs_size);

  logic                 alloc;
  logic                 lsq_full;
  logic                 rs_full;
  ooo_pkg::rob_entry    rob [rob_size-1:0];
  ooo_pkg::lsq_entry    lsq [lsq_size-1:0];
  ooo_pkg::rs_entry     res_stations [rs_size-1:0];
  ooo_pkg::tag_t        rob_head, rob_tail, lsq_head, lsq_tail, alloc_id;

  // Issue slots
  logic                 grant_valid1, grant_valid2;
  logic [rs_w-1:0]      rs_id1, rs_id2;
  ooo_pkg::tag_t        tag1, tag2;
  ooo_pkg::tag_t        lsq_id1, lsq_id2;
  ooo_pkg::word_t       source_a1, source_a2, source_b1, source_b2, data1, data2;
  ooo_pkg::control_bits ctrl_bits1, ctrl_bits2;

  // Broadcast buses and memory ports
  logic                 cdb_valid1, cdb_valid2;
  ooo_pkg::tag_t        cdb_tag1, cdb_tag2;
  ooo_pkg::word_t       cdb_value1, cdb_value2;
  logic                 mem_we1, mem_we2;
  ooo_pkg::word_t       mem_addr1, mem_addr2, mem_wdata1, mem_wdata2, mem_rdata1, mem_rdata2;

  reorder_buffer #(.rob_size(rob_size)) rob0 (
    .clk, .rst_n, .disp_req, .ctrl, .src2_tag, .src2_value, .disp_ack, .disp_tag,
    .commit_req, .commit_tag, .commit_result, .commit_is_store, .commit_store_data,
    .commit_ack, .alloc, .cdb_valid1, .cdb_tag1, .cdb_value1, .cdb_valid2, .cdb_tag2,
    .cdb_value2, .rob, .rob_head, .rob_tail, .lsq_full, .rs_full
  );

  // The ROB tail is the tag handed out on the allocating edge
  load_store_queue #(.lsq_size(lsq_size)) lsq0 (
    .clk, .rst_n, .alloc, .disp_tag(rob_tail), .is_mem(ctrl.memtoreg),
    .is_store(ctrl.memwr), .cdb_valid1, .cdb_tag1, .cdb_valid2, .cdb_tag2,
    .lsq, .lsq_head, .lsq_tail, .lsq_full, .alloc_id
  );

  res_station_file #(.rs_size(rs_size)) rs0 (
    .clk, .rst_n, .alloc, .disp_tag(rob_tail), .alloc_id, .ctrl, .src1_tag, .src1_value,
    .src2_tag, .src2_value, .imm, .grant_valid1, .grant_valid2, .rs_id1, .rs_id2,
    .cdb_valid1, .cdb_tag1, .cdb_value1, .cdb_valid2, .cdb_tag2, .cdb_value2,
    .res_stations, .rs_full
  );

  issue_select #(.rob_size(rob_size), .rs_size(rs_size), .lsq_size(lsq_size)) issue0 (
    .rob, .res_stations, .lsq, .rob_head, .rob_tail, .lsq_head, .lsq_tail,
    .grant_valid1, .grant_valid2, .tag1, .tag2, .rs_id1, .rs_id2,
    .lsq_id1, .lsq_id2, .source_a1, .source_a2, .source_b1, .source_b2,
    .data1, .data2, .ctrl_bits1, .ctrl_bits2
  );

  exec_lane lane1 (
    .clk, .rst_n, .grant_valid(grant_valid1), .tag(tag1), .source_a(source_a1),
    .source_b(source_b1), .data(data1), .ctrl_bits(ctrl_bits1), .mem_addr(mem_addr1),
    .mem_we(mem_we1), .mem_wdata(mem_wdata1), .mem_rdata(mem_rdata1),
    .cdb_valid(cdb_valid1), .cdb_tag(cdb_tag1), .cdb_value(cdb_value1)
  );

  exec_lane lane2 (
    .clk, .rst_n, .grant_valid(grant_valid2), .tag(tag2), .source_a(source_a2),
    .source_b(source_b2), .data(data2), .ctrl_bits(ctrl_bits2), .mem_addr(mem_addr2),
    .mem_we(mem_we2), .mem_wdata(mem_wdata2), .mem_rdata(mem_rdata2),
    .cdb_valid(cdb_valid2), .cdb_tag(cdb_tag2), .cdb_value(cdb_value2)
  );

  data_mem mem0 (
    .clk, .rst_n,
    .addr1(mem_addr1), .we1(mem_we1), .wdata1(mem_wdata1), .rdata1(mem_rdata1),
    .addr2(mem_addr2), .we2(mem_we2), .wdata2(mem_wdata2), .rdata2(mem_rdata2)
  );

endmodule

// File: rob/load_store_queue.sv
`timescale 1ns/100ps

module load_store_queue #(
  parameter int lsq_size = 4,
  localparam int lsq_w   = $clog2(lsq_size),
  localparam int cnt_w   = $clog2(lsq_size + 1)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alloc,
  input  ooo_pkg::tag_t     disp_tag,
  input  logic              is_mem,
  input  logic              is_store,
  input  logic              cdb_valid1,
  input  ooo_pkg::tag_t     cdb_tag1,
  input  logic              cdb_valid2,
  input  ooo_pkg::tag_t     cdb_tag2,
  output ooo_pkg::lsq_entry lsq [lsq_size-1:0],
  output ooo_pkg::tag_t     lsq_head,
  output ooo_pkg::tag_t     lsq_tail,
  output logic              lsq_full,
  output ooo_pkg::tag_t     alloc_id
);
  logic [cnt_w-1:0] count;
  logic             push;
  logic             retire;

  assign push     = alloc && is_mem;
  assign retire   = lsq[lsq_w'(lsq_head - 1'b1)].busy && lsq[lsq_w'(lsq_head - 1'b1)].executed;
  assign lsq_full = count == cnt_w'(lsq_size);
  assign alloc_id = lsq_tail;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsq_head <= ooo_pkg::tag_t'(1);
      lsq_tail <= ooo_pkg::tag_t'(1);
      count    <= '0;
      for (int i = 0; i < lsq_size; i++)
        lsq[i] <= '0;
    end else begin
      // Executed when its lane broadcasts
      for (int i = 0; i < lsq_size; i++) begin
        if (lsq[i].busy && ((cdb_valid1 && cdb_tag1 == lsq[i].rob_tag) ||
                            (cdb_valid2 && cdb_tag2 == lsq[i].rob_tag)))
          lsq[i].executed <= 1'b1;
      end
      if (retire) begin
        lsq[lsq_w'(lsq_head - 1'b1)].busy <= 1'b0;
        lsq_head <= ooo_pkg::wrap_inc(lsq_head, lsq_size);
      end
      if (push) begin
        lsq[lsq_w'(lsq_tail - 1'b1)] <= '{busy: 1'b1, executed: 1'b0,
                                          is_store: is_store, rob_tag: disp_tag};
        lsq_tail <= ooo_pkg::wrap_inc(lsq_tail, lsq_size);
      end
      count <= count + cnt_w'(push) - cnt_w'(retire);
    end
  end

endmodule

// File: rob/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer #(
  parameter int rob_size = 8,
  localparam int rob_w   = $clog2(rob_size),
  localparam int cnt_w   = $clog2(rob_size + 1)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 disp_req,
  input  ooo_pkg::control_bits ctrl,
  input  ooo_pkg::tag_t        src2_tag,
  input  ooo_pkg::word_t       src2_value,
  output logic                 disp_ack,
  output ooo_pkg::tag_t        disp_tag,
  output logic                 commit_req,
  output ooo_pkg::tag_t        commit_tag,
  output ooo_pkg::word_t       commit_result,
  output logic                 commit_is_store,
  output ooo_pkg::word_t       commit_store_data,
  input  logic                 commit_ack,
  output logic                 alloc,
  input  logic                 cdb_valid1,
  input  ooo_pkg::tag_t        cdb_tag1,
  input  ooo_pkg::word_t       cdb_value1,
  input  logic                 cdb_valid2,
  input  ooo_pkg::tag_t        cdb_tag2,
  input  ooo_pkg::word_t       cdb_value2,
  output ooo_pkg::rob_entry    rob [rob_size-1:0],
  output ooo_pkg::tag_t        rob_head,
  output ooo_pkg::tag_t        rob_tail,
  input  logic                 lsq_full,
  input  logic                 rs_full
);
  logic [cnt_w-1:0]  count;
  logic              retire;
  ooo_pkg::rob_entry head_e;
  // Producer tag of a store's data while it is still outstanding
  ooo_pkg::tag_t     st_tag [rob_size-1:0];
  ooo_pkg::tag_t     disp_wait;
  ooo_pkg::word_t    disp_data;

  assign alloc = disp_req && !disp_ack && count != cnt_w'(rob_size) && !rs_full &&
                 !(ctrl.memtoreg && lsq_full);
  assign retire = commit_req && commit_ack;

  assign head_e            = rob[rob_w'(rob_head - 1'b1)];
  assign commit_tag        = rob_head;
  assign commit_result     = head_e.result;
  assign commit_is_store   = head_e.ctrl_bits.memwr;
  assign commit_store_data = head_e.store_data;

  // Store data known now, or the tag still to be watched
  always_comb begin
    disp_data = src2_value;
    disp_wait = ctrl.memwr ? src2_tag : '0;
    if (src2_tag != '0 && cdb_valid1 && cdb_tag1 == src2_tag) begin
      disp_data = cdb_value1;
      disp_wait = '0;
    end else if (src2_tag != '0 && cdb_valid2 && cdb_tag2 == src2_tag) begin
      disp_data = cdb_value2;
      disp_wait = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      disp_ack   <= 1'b0;
      disp_tag   <= '0;
      commit_req <= 1'b0;
      rob_head   <= ooo_pkg::tag_t'(1);
      rob_tail   <= ooo_pkg::tag_t'(1);
      count      <= '0;
      for (int i = 0; i < rob_size; i++) begin
        rob[i]    <= '0;
        st_tag[i] <= '0;
      end
    end else begin
      // Ack rises on acceptance and falls once req is gone
      if (alloc)
        disp_ack <= 1'b1;
      else if (!disp_req)
        disp_ack <= 1'b0;

      if (cdb_valid1) begin
        rob[rob_w'(cdb_tag1 - 1'b1)].done   <= 1'b1;
        rob[rob_w'(cdb_tag1 - 1'b1)].result <= cdb_value1;
      end
      if (cdb_valid2) begin
        rob[rob_w'(cdb_tag2 - 1'b1)].done   <= 1'b1;
        rob[rob_w'(cdb_tag2 - 1'b1)].result <= cdb_value2;
      end
      for (int i = 0; i < rob_size; i++) begin
        if (st_tag[i] != '0 && cdb_valid1 && cdb_tag1 == st_tag[i]) begin
          rob[i].store_data <= cdb_value1;
          st_tag[i]         <= '0;
        end else if (st_tag[i] != '0 && cdb_valid2 && cdb_tag2 == st_tag[i]) begin
          rob[i].store_data <= cdb_value2;
          st_tag[i]         <= '0;
        end
      end

      // In-order commit, next entry only after ack has dropped
      if (commit_req) begin
        if (commit_ack) begin
          commit_req <= 1'b0;
          rob[rob_w'(rob_head - 1'b1)].busy <= 1'b0;
          rob[rob_w'(rob_head - 1'b1)].done <= 1'b0;
          rob_head <= ooo_pkg::wrap_inc(rob_head, rob_size);
        end
      end else if (!commit_ack && head_e.busy && head_e.done) begin
        commit_req <= 1'b1;
      end

      if (alloc) begin
        rob[rob_w'(rob_tail - 1'b1)] <= '{busy: 1'b1, done: 1'b0, ctrl_bits: ctrl,
                                          result: '0, store_data: disp_data};
        st_tag[rob_w'(rob_tail - 1'b1)] <= disp_wait;
        disp_tag <= rob_tail;
        rob_tail <= ooo_pkg::wrap_inc(rob_tail, rob_size);
      end
      count <= count + cnt_w'(alloc) - cnt_w'(retire);
    end
  end

endmodule

// File: issue/res_station_file.sv
`timescale 1ns/100ps

module res_station_file #(
  parameter int rs_size = 4,
  localparam int rs_w   = $clog2(rs_size)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 alloc,
  input  ooo_pkg::tag_t        disp_tag,
  input  ooo_pkg::tag_t        alloc_id,
  input  ooo_pkg::control_bits ctrl,
  input  ooo_pkg::tag_t        src1_tag,
  input  ooo_pkg::word_t       src1_value,
  input  ooo_pkg::tag_t        src2_tag,
  input  ooo_pkg::word_t       src2_value,
  input  ooo_pkg::word_t       imm,
  input  logic                 grant_valid1,
  input  logic                 grant_valid2,
  input  logic [rs_w-1:0]      rs_id1,
  input  logic [rs_w-1:0]      rs_id2,
  input  logic                 cdb_valid1,
  input  ooo_pkg::tag_t        cdb_tag1,
  input  ooo_pkg::word_t       cdb_value1,
  input  logic                 cdb_valid2,
  input  ooo_pkg::tag_t        cdb_tag2,
  input  ooo_pkg::word_t       cdb_value2,
  output ooo_pkg::rs_entry     res_stations [rs_size-1:0],
  output logic                 rs_full
);
  logic [rs_w-1:0]  free_id;
  ooo_pkg::rs_entry new_entry;

  function automatic logic hit(ooo_pkg::tag_t t, logic v, ooo_pkg::tag_t ct);
    return v && t != '0 && t == ct;
  endfunction

  // Lowest free station
  always_comb begin
    free_id = '0;
    rs_full = 1'b1;
    for (int i = rs_size - 1; i >= 0; i--) begin
      if (!res_stations[i].busy) begin
        free_id = rs_w'(i);
        rs_full = 1'b0;
      end
    end
  end

  // Incoming operands may be resolved by a broadcast in the same cycle
  always_comb begin
    new_entry = '{busy: 1'b1, tag: disp_tag, lsq_id: alloc_id, tag_1: src1_tag,
                  tag_2: src2_tag, value_1: src1_value, value_2: src2_value,
                  imm: imm, ctrl_bits: ctrl};
    if (hit(src1_tag, cdb_valid1, cdb_tag1)) begin
      new_entry.tag_1   = '0;
      new_entry.value_1 = cdb_value1;
    end else if (hit(src1_tag, cdb_valid2, cdb_tag2)) begin
      new_entry.tag_1   = '0;
      new_entry.value_1 = cdb_value2;
    end
    if (hit(src2_tag, cdb_valid1, cdb_tag1)) begin
      new_entry.tag_2   = '0;
      new_entry.value_2 = cdb_value1;
    end else if (hit(src2_tag, cdb_valid2, cdb_tag2)) begin
      new_entry.tag_2   = '0;
      new_entry.value_2 = cdb_value2;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < rs_size; i++)
        res_stations[i] <= '0;
    end else begin
      // Wakeup
      for (int i = 0; i < rs_size; i++) begin
        if (res_stations[i].busy) begin
          if (hit(res_stations[i].tag_1, cdb_valid1, cdb_tag1)) begin
            res_stations[i].tag_1   <= '0;
            res_stations[i].value_1 <= cdb_value1;
          end else if (hit(res_stations[i].tag_1, cdb_valid2, cdb_tag2)) begin
            res_stations[i].tag_1   <= '0;
            res_stations[i].value_1 <= cdb_value2;
          end
          if (hit(res_stations[i].tag_2, cdb_valid1, cdb_tag1)) begin
            res_stations[i].tag_2   <= '0;
            res_stations[i].value_2 <= cdb_value1;
          end else if (hit(res_stations[i].tag_2, cdb_valid2, cdb_tag2)) begin
            res_stations[i].tag_2   <= '0;
            res_stations[i].value_2 <= cdb_value2;
          end
        end
      end
      if (grant_valid1)
        res_stations[rs_id1].busy <= 1'b0;
      if (grant_valid2)
        res_stations[rs_id2].busy <= 1'b0;
      if (alloc)
        res_stations[free_id] <= new_entry;
    end
  end

endmodule

// File: issue/issue_select.sv
`timescale 1ns/100ps

module issue_select #(
  parameter int rob_size = 8,
  parameter int rs_size  = 4,
  parameter int lsq_size = 4,
  localparam int rs_w    = $clog2(rs_size)
) (
  // Full state of the stations, the ROB and the queue
  input  ooo_pkg::rob_entry    rob [rob_size-1:0],
  input  ooo_pkg::rs_entry     res_stations [rs_size-1:0],
  input  ooo_pkg::lsq_entry    lsq [lsq_size-1:0],
  input  ooo_pkg::tag_t        rob_head,
  input  ooo_pkg::tag_t        rob_tail,
  input  ooo_pkg::tag_t        lsq_head,
  input  ooo_pkg::tag_t        lsq_tail,

  // Two issue slots
  output logic                 grant_valid1, grant_valid2,
  output ooo_pkg::tag_t        tag1,         tag2,
  output logic [rs_w-1:0]      rs_id1,       rs_id2,
  output ooo_pkg::tag_t        lsq_id1,      lsq_id2,
  output ooo_pkg::word_t       source_a1,    source_a2,
  output ooo_pkg::word_t       source_b1,    source_b2,
  output ooo_pkg::word_t       data1,        data2,
  output ooo_pkg::control_bits ctrl_bits1,   ctrl_bits2
);
  ooo_pkg::rs_entry sel1, sel2;

  // True when position i is older than entry id, wraparound included
  function automatic logic older(int i, int head, int tail, int id);
    if (head < tail)
      return i >= head && i < id && i < tail;
    else if (id >= head)
      return i >= head && i < id;
    else
      return i >= head || i < id;
  endfunction

  function automatic logic earlier_store(ooo_pkg::tag_t lsq_id);
    logic found;
    found = 1'b0;
    for (int i = 1; i <= lsq_size; i++) begin
      if (older(i, lsq_head, lsq_tail, lsq_id) && lsq[i-1].busy && lsq[i-1].is_store)
        found = 1'b1;
    end
    return found;
  endfunction

  function automatic logic earlier_jump(ooo_pkg::tag_t rob_tag);
    logic found;
    found = 1'b0;
    for (int i = 1; i <= rob_size; i++) begin
      if (older(i, rob_head, rob_tail, rob_tag) && rob[i-1].busy &&
          (rob[i-1].ctrl_bits.ucjump || rob[i-1].ctrl_bits.cjump))
        found = 1'b1;
    end
    return found;
  endfunction

  function automatic logic can_issue(ooo_pkg::rs_entry e);
    logic ok;
    ok = e.busy && e.tag_1 == '0 && e.tag_2 == '0;
    // Memory ops wait behind older stores and uncommitted jumps
    if (e.ctrl_bits.memtoreg && (earlier_store(e.lsq_id) || earlier_jump(e.tag)))
      ok = 1'b0;
    // Stores only from the queue head
    if (e.ctrl_bits.memwr && e.lsq_id != lsq_head)
      ok = 1'b0;
    return ok;
  endfunction

  // First two ready stations in index order
  always_comb begin
    grant_valid1 = 1'b0;
    grant_valid2 = 1'b0;
    rs_id1 = '0;
    rs_id2 = '0;
    for (int i = 0; i < rs_size; i++) begin
      if (can_issue(res_stations[i])) begin
        if (!grant_valid1) begin
          grant_valid1 = 1'b1;
          rs_id1 = rs_w'(i);
        end else if (!grant_valid2) begin
          grant_valid2 = 1'b1;
          rs_id2 = rs_w'(i);
        end
      end
    end
  end

  assign sel1 = res_stations[rs_id1];
  assign sel2 = res_stations[rs_id2];

  assign tag1       = sel1.tag;
  assign lsq_id1    = sel1.lsq_id;
  assign source_a1  = sel1.value_1;
  assign source_b1  = sel1.ctrl_bits.alusrc ? sel1.imm : sel1.value_2;
  assign data1      = sel1.ctrl_bits.memwr ? sel1.value_2 : '0;
  assign ctrl_bits1 = sel1.ctrl_bits;

  assign tag2       = sel2.tag;
  assign lsq_id2    = sel2.lsq_id;
  assign source_a2  = sel2.value_1;
  assign source_b2  = sel2.ctrl_bits.alusrc ? sel2.imm : sel2.value_2;
  assign data2      = sel2.ctrl_bits.memwr ? sel2.value_2 : '0;
  assign ctrl_bits2 = sel2.ctrl_bits;

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/100ps

module data_mem (
  input  logic           clk,
  input  logic           rst_n,
  input  ooo_pkg::word_t addr1,
  input  logic           we1,
  input  ooo_pkg::word_t wdata1,
  output ooo_pkg::word_t rdata1,
  input  ooo_pkg::word_t addr2,
  input  logic           we2,
  input  ooo_pkg::word_t wdata2,
  output ooo_pkg::word_t rdata2
);
  ooo_pkg::word_t mem [16];

  assign rdata1 = mem[addr1[3:0]];
  assign rdata2 = mem[addr2[3:0]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++)
        mem[i] <= '0;
    end else begin
      if (we1)
        mem[addr1[3:0]] <= wdata1;
      // Lane 2 wins a same-address collision
      if (we2)
        mem[addr2[3:0]] <= wdata2;
    end
  end

endmodule

// File: verilog/exec_lane.sv
`timescale 1ns/100ps

module exec_lane (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 grant_valid,
  input  ooo_pkg::tag_t        tag,
  input  ooo_pkg::word_t       source_a,
  input  ooo_pkg::word_t       source_b,
  input  ooo_pkg::word_t       data,
  input  ooo_pkg::control_bits ctrl_bits,
  output ooo_pkg::word_t       mem_addr,
  output logic                 mem_we,
  output ooo_pkg::word_t       mem_wdata,
  input  ooo_pkg::word_t       mem_rdata,
  output logic                 cdb_valid,
  output ooo_pkg::tag_t        cdb_tag,
  output ooo_pkg::word_t       cdb_value
);
  ooo_pkg::word_t       alu_out;
  ooo_pkg::word_t       result_q;
  ooo_pkg::control_bits ctrl_q;

  always_comb begin
    case (ctrl_bits.alu_op)
      ooo_pkg::ALU_SUB: alu_out = source_a - source_b;
      ooo_pkg::ALU_AND: alu_out = source_a & source_b;
      ooo_pkg::ALU_XOR: alu_out = source_a ^ source_b;
      default:          alu_out = source_a + source_b;
    endcase
    // Address for loads and stores
    if (ctrl_bits.memtoreg)
      alu_out = source_a + source_b;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      cdb_valid <= 1'b0;
    else
      cdb_valid <= grant_valid;
  end

  always_ff @(posedge clk) begin
    cdb_tag   <= tag;
    result_q  <= alu_out;
    mem_wdata <= data;
    ctrl_q    <= ctrl_bits;
  end

  assign mem_addr = result_q;
  assign mem_we   = cdb_valid && ctrl_q.memwr;
  // Loads return the memory word, stores and ALU ops the registered sum
  assign cdb_value = (ctrl_q.memtoreg && !ctrl_q.memwr) ? mem_rdata : result_q;

endmodule

// File: common/ooo_pkg.sv
package ooo_pkg;

  typedef logic [31:0] word_t;

  // 1-based index into the ROB or the load/store queue
  // Zero in an operand tag means the value is already present
  typedef logic [7:0] tag_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_AND = 2'd2,
    ALU_XOR = 2'd3
  } alu_op_t;

  // Stores set memwr and memtoreg together
  typedef struct packed {
    alu_op_t alu_op;
    logic    alusrc;
    logic    memtoreg;
    logic    memwr;
    logic    cjump;
    logic    ucjump;
  } control_bits;

  typedef struct packed {
    logic        busy;
    tag_t        tag;
    tag_t        lsq_id;
    tag_t        tag_1;
    tag_t        tag_2;
    word_t       value_1;
    word_t       value_2;
    word_t       imm;
    control_bits ctrl_bits;
  } rs_entry;

  typedef struct packed {
    logic        busy;
    logic        done;
    control_bits ctrl_bits;
    word_t       result;
    word_t       store_data;
  } rob_entry;

  typedef struct packed {
    logic busy;
    logic executed;
    logic is_store;
    tag_t rob_tag;
  } lsq_entry;

  // Advance a 1-based circular pointer
  function automatic tag_t wrap_inc(tag_t t, int size);
    return (int'(t) == size) ? tag_t'(1) : t + tag_t'(1);
  endfunction

endpackage
